//--- logic/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH
`default_nettype none

// ======================================================================
// datapath and thread geometry
// ======================================================================
`define FU_XLEN             32              // address and instruction word width
`define FU_THREADS          4               // hardware threads
`define FU_TID_W            2               // thread index width, log2 of threads

// prefetch buffering, depth must be a power of two
`define FU_IBUF_DEPTH       4               // entries per thread buffer
`define FU_CREDIT_W         3               // counts 0..depth inclusive

// boot map, thread t starts at base + t * stride
`define FU_BOOT_BASE        32'h0000_1000
`define FU_THREAD_STRIDE    32'h0000_0400
`define FU_INSTR_BYTES      4               // pc step per fetched word

`default_nettype wire
`endif

//--- logic/fetch_pkg.sv
`include "fetch_settings.svh"
`default_nettype none

package fetch_pkg;

    // ======================================================================
    // sequencer state
    // ======================================================================
    // one request state only, the thread lives in a separate index register
    typedef enum logic [1:0] {
        FS_RESTART = 2'b00,     // reload pcs, flush buffers, refill credits
        FS_PEND    = 2'b01,     // idle, waiting for any thread with a credit
        FS_REQ     = 2'b10      // read on the bus, waiting for ack
    } fetch_state_t;

    // ======================================================================
    // thread index
    // ======================================================================
    typedef logic [`FU_TID_W-1:0] tid_t;   // wraps naturally over all threads

endpackage : fetch_pkg

`default_nettype wire

//--- logic/fetch_sequencer.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"
`default_nettype none

module fetch_sequencer (
    input  wire                                 i_clk,
    input  wire                                 i_rstn,
    input  wire                                 i_restart,      // restart pulse
    input  wire                                 i_bus_rsp_ack,  // bus response valid
    input  wire [`FU_THREADS-1:0]               i_pop,          // credit return per thread
    input  wire [`FU_THREADS-1:0][`FU_XLEN-1:0] i_pc_vec,       // all thread pcs
    output logic                                o_bus_req_re,   // read request
    output logic [`FU_XLEN-1:0]                 o_bus_req_addr, // pc of current thread
    output logic                                o_pc_load,      // reload all pcs
    output logic                                o_pc_adv,       // advance one pc
    output fetch_pkg::tid_t                     o_adv_tid,      // which pc to advance
    output logic [`FU_THREADS-1:0]              o_buf_we,       // one-hot buffer write
    output logic                                o_buf_clear     // flush all buffers
);
    import fetch_pkg::*;

    localparam int NT = `FU_THREADS;
    localparam int CW = `FU_CREDIT_W;
    localparam logic [CW-1:0] CRED_FULL = CW'(`FU_IBUF_DEPTH); // one per free slot
    localparam logic [CW-1:0] CRED_ONE  = CW'(1);

    fetch_state_t   state_q;
    fetch_state_t   state_d;
    tid_t           tid_q;              // thread in flight, or last served
    tid_t           pick_tid;           // next thread by rotating priority
    logic           pick_found;         // some thread holds a credit
    logic           pick_en;            // a pick may happen this cycle
    logic           issue;              // new request starts next cycle
    logic           rsp;                // ack for our request
    logic [NT-1:0]  has_credit;
    logic [CW-1:0]  credit_q [NT];

    // ======================================================================
    // rotating priority pick
    // ======================================================================
    // search starts at the thread after tid_q, tid_q itself is tried last
    always_comb begin
        tid_t cand;
        pick_found = 1'b0;
        pick_tid   = tid_q;
        for (int i = 1; i <= NT; i++) begin
            cand = tid_q + tid_t'(i);           // wraps mod thread count
            if (!pick_found && has_credit[cand]) begin
                pick_found = 1'b1;
                pick_tid   = cand;
            end
        end
    end

    assign rsp     = (state_q == FS_REQ) && i_bus_rsp_ack;
    assign pick_en = (state_q == FS_PEND) || rsp;           // idle or request retiring
    assign issue   = pick_en && pick_found && !i_restart;   // restart wins over issue

    // ======================================================================
    // control FSM
    // ======================================================================
    always_comb begin
        state_d = state_q;
        if (i_restart) begin
            state_d = FS_RESTART;               // drops any request in flight
        end else begin
            case (state_q)
                FS_RESTART: state_d = FS_PEND;
                FS_PEND:    if (pick_found) state_d = FS_REQ;
                FS_REQ: begin
                    // hold until ack, then chain straight into next pick
                    if (i_bus_rsp_ack) state_d = pick_found ? FS_REQ : FS_PEND;
                end
                default:    state_d = FS_RESTART;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state_q <= FS_RESTART;
            tid_q   <= tid_t'(NT-1);            // first search begins at thread 0
        end else begin
            state_q <= state_d;
            if (state_q == FS_RESTART)
                tid_q <= tid_t'(NT-1);
            else if (issue)
                tid_q <= pick_tid;              // held steady while request waits
        end
    end

    // ======================================================================
    // per-thread credits
    // ======================================================================
    for (genvar t = 0; t < NT; t++) begin : g_credit
        logic take;                             // credit spent by this issue

        assign take          = issue && (pick_tid == tid_t'(t));
        assign has_credit[t] = (credit_q[t] != '0);

        always_ff @(posedge i_clk or negedge i_rstn) begin
            if (!i_rstn)
                credit_q[t] <= CRED_FULL;
            else if (state_q == FS_RESTART)
                credit_q[t] <= CRED_FULL;       // buffers flushed this edge
            else if (i_pop[t] && !take)
                credit_q[t] <= credit_q[t] + CRED_ONE;
            else if (take && !i_pop[t])
                credit_q[t] <= credit_q[t] - CRED_ONE;
            // pop and take together cancel out
        end
    end

    // ======================================================================
    // bus, pc and buffer steering
    // ======================================================================
    assign o_bus_req_re   = (state_q == FS_REQ);
    assign o_bus_req_addr = i_pc_vec[tid_q];    // stable, pc only moves on ack
    assign o_pc_load      = (state_q == FS_RESTART);
    assign o_buf_clear    = (state_q == FS_RESTART);
    assign o_pc_adv       = rsp;
    assign o_adv_tid      = tid_q;
    assign o_buf_we       = rsp ? (NT'(1) << tid_q) : '0; // word goes to requester

endmodule : fetch_sequencer

`default_nettype wire

//--- logic/thread_pc_bank.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"
`default_nettype none

module thread_pc_bank (
    input  wire                                  i_clk,
    input  wire                                  i_rstn,
    input  wire                                  i_load,     // reload every pc with boot addr
    input  wire                                  i_adv,      // step one pc
    input  fetch_pkg::tid_t                      i_adv_tid,  // thread to step
    output logic [`FU_THREADS-1:0][`FU_XLEN-1:0] o_pc_vec    // packed, thread 0 lowest
);

    localparam logic [`FU_XLEN-1:0] STEP = `FU_INSTR_BYTES;

    // ======================================================================
    // one program counter per thread
    // ======================================================================
    for (genvar t = 0; t < `FU_THREADS; t++) begin : g_pc
        // boot address of this thread
        localparam logic [`FU_XLEN-1:0] BOOT   = `FU_BOOT_BASE + t * `FU_THREAD_STRIDE;
        localparam logic [`FU_TID_W-1:0] MY_TID = `FU_TID_W'(t);

        logic [`FU_XLEN-1:0] pc_q;

        always_ff @(posedge i_clk or negedge i_rstn) begin
            if (!i_rstn) begin
                pc_q <= BOOT;
            end else if (i_load) begin
                pc_q <= BOOT;                   // restart, load has priority
            end else if (i_adv && (i_adv_tid == MY_TID)) begin
                pc_q <= pc_q + STEP;            // word for this thread came back
            end
        end

        assign o_pc_vec[t] = pc_q;
    end

endmodule : thread_pc_bank

`default_nettype wire

//--- logic/prefetch_buffer.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"
`default_nettype none

module prefetch_buffer #(
    parameter int DEPTH = 4                     // entries, power of two, at least 2
) (
    input  wire                 i_clk,
    input  wire                 i_rstn,
    input  wire                 i_clear,        // flush, pointers back to zero
    // write side, from the bus
    input  wire                 i_we,           // store a fetched word
    input  wire [`FU_XLEN-1:0]  i_wdata,        // instruction word
    input  wire                 i_werr,         // bus error for that word
    // read side, to the decoder
    input  wire                 i_re,           // pop request
    output logic                o_avail,        // head entry valid
    output logic [`FU_XLEN-1:0] o_rdata,        // head word, fall through
    output logic                o_rerr,         // head error bit
    output logic                o_pop           // accepted pop, also the credit return
);

    localparam int AW = $clog2(DEPTH);
    localparam int DW = `FU_XLEN + 1;           // {err, word}

    localparam logic [AW:0] PTR_ONE = (AW+1)'(1);

    // ======================================================================
    // storage and pointers
    // ======================================================================
    logic [DW-1:0] mem_q [DEPTH];               // payload only, no reset
    logic [AW:0]   wptr_q;                      // msb is the wrap bit
    logic [AW:0]   rptr_q;
    logic [DW-1:0] head;

    // no full check, the sequencer credits keep room for every write
    always_ff @(posedge i_clk) begin
        if (i_we)
            mem_q[wptr_q[AW-1:0]] <= {i_werr, i_wdata};
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else if (i_clear) begin
            wptr_q <= '0;                       // drop everything
            rptr_q <= '0;
        end else begin
            if (i_we)
                wptr_q <= wptr_q + PTR_ONE;
            if (o_pop)
                rptr_q <= rptr_q + PTR_ONE;
        end
    end

    // ======================================================================
    // first word fall through read
    // ======================================================================
    // equal index with different wrap bits means full, so still available
    assign o_avail = (rptr_q != wptr_q);
    assign head    = mem_q[rptr_q[AW-1:0]];     // async read of head slot
    assign o_rdata = head[`FU_XLEN-1:0];
    assign o_rerr  = head[DW-1];
    assign o_pop   = i_re && o_avail;           // pop on empty is ignored

endmodule : prefetch_buffer

`default_nettype wire

//--- logic/fetch_unit_top.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"
`default_nettype none

module fetch_unit_top (
    input  wire                                  i_clk,
    input  wire                                  i_rstn,
    input  wire                                  i_restart,      // reload pcs, flush buffers
    // instruction bus, read only
    output logic                                 o_bus_req_re,   // request valid
    output logic [`FU_XLEN-1:0]                  o_bus_req_addr, // word aligned address
    input  wire                                  i_bus_rsp_ack,  // response, one cycle
    input  wire  [`FU_XLEN-1:0]                  i_bus_rsp_data, // read data
    input  wire                                  i_bus_rsp_err,  // access error
    // decoder side, one lane per thread
    input  wire  [`FU_THREADS-1:0]               i_ibuf_re,      // pop
    output logic [`FU_THREADS-1:0]               o_ibuf_avail,   // word ready
    output logic [`FU_THREADS-1:0][`FU_XLEN-1:0] o_ibuf_instr,   // instruction word
    output logic [`FU_THREADS-1:0]               o_ibuf_berr     // bus error on that word
);
    import fetch_pkg::*;

    // ======================================================================
    // internal wiring
    // ======================================================================
    logic                                 pc_load;    // restart reload
    logic                                 pc_adv;     // ack, step a pc
    tid_t                                 adv_tid;
    logic [`FU_THREADS-1:0][`FU_XLEN-1:0] pc_vec;
    logic [`FU_THREADS-1:0]               buf_we;     // one-hot per thread
    logic                                 buf_clear;
    logic [`FU_THREADS-1:0]               pop;        // credit returns

    // control, credits and bus steering
    fetch_sequencer fetch_sequencer_i (
        .i_clk          (i_clk),
        .i_rstn         (i_rstn),
        .i_restart      (i_restart),
        .i_bus_rsp_ack  (i_bus_rsp_ack),
        .i_pop          (pop),
        .i_pc_vec       (pc_vec),
        .o_bus_req_re   (o_bus_req_re),
        .o_bus_req_addr (o_bus_req_addr),
        .o_pc_load      (pc_load),
        .o_pc_adv       (pc_adv),
        .o_adv_tid      (adv_tid),
        .o_buf_we       (buf_we),
        .o_buf_clear    (buf_clear)
    );

    // pcs for all threads
    thread_pc_bank thread_pc_bank_i (
        .i_clk          (i_clk),
        .i_rstn         (i_rstn),
        .i_load         (pc_load),
        .i_adv          (pc_adv),
        .i_adv_tid      (adv_tid),
        .o_pc_vec       (pc_vec)
    );

    // ======================================================================
    // prefetch buffers
    // ======================================================================
    // response data fans out to every buffer, buf_we picks the one
    for (genvar t = 0; t < `FU_THREADS; t++) begin : g_ibuf
        prefetch_buffer #(
            .DEPTH      (`FU_IBUF_DEPTH)
        ) prefetch_buffer_i (
            .i_clk      (i_clk),
            .i_rstn     (i_rstn),
            .i_clear    (buf_clear),
            .i_we       (buf_we[t]),
            .i_wdata    (i_bus_rsp_data),
            .i_werr     (i_bus_rsp_err),
            .i_re       (i_ibuf_re[t]),
            .o_avail    (o_ibuf_avail[t]),
            .o_rdata    (o_ibuf_instr[t]),
            .o_rerr     (o_ibuf_berr[t]),
            .o_pop      (pop[t])
        );
    end

endmodule : fetch_unit_top

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter realtime PERIOD     = 4.0,     // ns
    parameter int      RST_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk  = 1'b0;
        o_rstn = 1'b0;                      // held low from time zero
        repeat (RST_CYCLES) @(posedge o_clk);
        #1 o_rstn = 1'b1;                   // released off the edge
    end

    always #(PERIOD / 2.0) o_clk = ~o_clk;

endmodule : tb_clock_gen

`default_nettype wire

//--- verif/fetch_assertions.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"
`default_nettype none

module fetch_assertions (
    input wire                                  i_clk,
    input wire                                  i_rstn,
    input wire                                  i_restart,
    input wire                                  o_bus_req_re,
    input wire [`FU_XLEN-1:0]                   o_bus_req_addr,
    input wire                                  i_bus_rsp_ack,
    input wire [`FU_THREADS-1:0]                o_ibuf_avail,
    input wire [`FU_THREADS-1:0][`FU_XLEN-1:0]  o_ibuf_instr
);

    // a waiting request keeps its address until ack
    a_addr_stable : assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_bus_req_re && !i_bus_rsp_ack && !i_restart
        |=> o_bus_req_re && $stable(o_bus_req_addr))
        else $error("bus request dropped or address moved before ack");

    // restart cycle, then idle pend cycle, no request in either
    a_restart_quiet : assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_restart |=> !o_bus_req_re ##1 !o_bus_req_re)
        else $error("bus request issued right after restart");

    for (genvar t = 0; t < `FU_THREADS; t++) begin : g_known
        a_instr_known : assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_ibuf_avail[t] |-> !$isunknown(o_ibuf_instr[t]))
            else $error("unknown instruction word on an available buffer");
    end

endmodule : fetch_assertions

`default_nettype wire

//--- verif/tb_fetch_checker.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"
`default_nettype none

module tb_fetch_checker (
    input  wire                                 i_clk,
    input  wire                                 i_rstn,
    input  wire                                 i_restart,
    input  wire  [1:0]                          i_phase,        // 1 = thread 3 starved
    input  wire                                 i_bus_req_re,
    input  wire  [`FU_XLEN-1:0]                 i_bus_req_addr,
    input  wire                                 i_bus_rsp_ack,
    input  wire  [`FU_THREADS-1:0]              i_ibuf_re,
    input  wire  [`FU_THREADS-1:0]              i_ibuf_avail,
    input  wire  [`FU_THREADS-1:0][`FU_XLEN-1:0] i_ibuf_instr,
    input  wire  [`FU_THREADS-1:0]              i_ibuf_berr,
    output int                                  o_errors
);

    localparam int NT     = `FU_THREADS;
    localparam int DEPTH  = `FU_IBUF_DEPTH;
    localparam int GOLD_N = 32;

    logic [31:0] gold [3*GOLD_N];           // addr, data, err triples
    logic [31:0] fifo [NT][$];              // expected addresses per buffer
    logic [31:0] next_pc [NT];
    int          credit [NT];
    int          issued [NT];               // requests since last restart
    int          last_tid;
    int          out_tid;                   // thread in flight
    int          rs;                        // restart window step
    bit          exp_req;
    logic [31:0] exp_addr;

    // golden lookup with fill rule for unlisted words
    function automatic logic [32:0] expect_word(input logic [31:0] addr);
        for (int i = 0; i < GOLD_N; i++) begin
            if (!$isunknown(gold[3*i]) && gold[3*i] == addr)
                return {gold[3*i+2][0], gold[3*i+1]};
        end
        return {1'b0, addr ^ 32'hA5A5_A5A5};
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
        $display("ERROR %s expected %h got %h at %0t", name, exp_v, got_v, $time);
        o_errors++;
    endtask

    task automatic reset_model();
        for (int t = 0; t < NT; t++) begin
            credit[t]  = DEPTH;
            issued[t]  = 0;
            next_pc[t] = `FU_BOOT_BASE + t * `FU_THREAD_STRIDE;
            fifo[t].delete();
        end
        last_tid = NT - 1;                  // first search starts at thread 0
    endtask

    initial begin
        $readmemh("verif/fetch_golden.txt", gold);
        o_errors = 0;
        exp_req  = 1'b0;
        rs       = 1;
        reset_model();
    end

    // ======================================================================
    // per cycle model sampled mid cycle
    // ======================================================================
    always @(negedge i_clk) begin
        logic [32:0]   w;
        logic [NT-1:0] popped;
        int            pick;
        int            c;
        popped = '0;
        if (!i_rstn) begin
            reset_model();
            rs      = 1;
            exp_req = 1'b0;
        end else begin
            // bus request against prediction
            if (i_bus_req_re !== exp_req)
                value_error("o_bus_req_re", 32'(exp_req), 32'(i_bus_req_re));
            else if (exp_req && i_bus_req_addr !== exp_addr)
                value_error("o_bus_req_addr", exp_addr, i_bus_req_addr);
            // buffer heads and pops
            for (int t = 0; t < NT; t++) begin
                if (i_ibuf_avail[t] !== (fifo[t].size() > 0)) begin
                    value_error($sformatf("o_ibuf_avail[%0d]", t),
                                32'(fifo[t].size() > 0), 32'(i_ibuf_avail[t]));
                end else if (i_ibuf_avail[t]) begin
                    w = expect_word(fifo[t][0]);
                    if (i_ibuf_instr[t] !== w[31:0])
                        value_error($sformatf("o_ibuf_instr[%0d]", t), w[31:0],
                                    i_ibuf_instr[t]);
                    if (i_ibuf_berr[t] !== w[32])
                        value_error($sformatf("o_ibuf_berr[%0d]", t), 32'(w[32]),
                                    32'(i_ibuf_berr[t]));
                    if (i_ibuf_re[t]) begin
                        void'(fifo[t].pop_front());
                        popped[t] = 1'b1;
                    end
                end
            end
            // ack writes the requester's buffer
            if (i_bus_req_re && i_bus_rsp_ack) begin
                fifo[out_tid].push_back(next_pc[out_tid]);
                next_pc[out_tid] += `FU_INSTR_BYTES;
                if (fifo[out_tid].size() > DEPTH) begin
                    $display("buffer of thread %0d overrun at %0t", out_tid, $time);
                    o_errors++;
                end
            end
            if (i_restart) begin
                if (i_phase == 2'd1) begin
                    if (issued[3] != DEPTH) begin
                        $display("thread 3 got %0d requests without pops, not %0d",
                                 issued[3], DEPTH);
                        o_errors++;
                    end
                    for (int t = 0; t < 3; t++) begin
                        if (issued[t] <= DEPTH) begin
                            $display("thread %0d stalled with %0d requests", t, issued[t]);
                            o_errors++;
                        end
                    end
                end
                rs      = 1;                // next cycle is the restart state
                exp_req = 1'b0;
            end else if (rs == 1) begin
                reset_model();              // clear edge drops pops too
                popped  = '0;
                rs      = 2;
                exp_req = 1'b0;
            end else if (i_bus_req_re && !i_bus_rsp_ack) begin
                rs      = 0;
                exp_req = 1'b1;             // still waiting on same address
            end else begin
                rs   = 0;
                pick = -1;
                for (int i = 1; i <= NT; i++) begin
                    c = (last_tid + i) % NT;
                    if (pick < 0 && credit[c] > 0)
                        pick = c;
                end
                exp_req = (pick >= 0);
                if (pick >= 0) begin
                    exp_addr = next_pc[pick];
                    credit[pick]--;
                    issued[pick]++;
                    last_tid = pick;
                    out_tid  = pick;
                end
            end
            // credits come back after the pick of this cycle
            for (int t = 0; t < NT; t++)
                if (popped[t])
                    credit[t]++;
        end
    end

endmodule : tb_fetch_checker

`default_nettype wire

//--- verif/tb_fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"
`default_nettype none

module tb_fetch_unit;

    localparam int NT      = `FU_THREADS;
    localparam int GOLD_N  = 32;
    localparam int TIMEOUT = 5000;          // cycles per wait loop

    logic                     clk;
    logic                     rstn;
    logic                     restart;
    logic                     restart_cmd;  // set by the sequence, driven by stimulus
    logic                     req_re;
    logic [31:0]              req_addr;
    logic                     ack;
    logic [31:0]              rsp_data;
    logic                     rsp_err;
    logic [NT-1:0]            ibuf_re;
    logic [NT-1:0]            avail;
    logic [NT-1:0][31:0]      instr;
    logic [NT-1:0]            berr;
    logic [31:0]              gold [3*GOLD_N];
    logic [1:0]               phase;
    integer                   seed;
    integer                   r;
    int                       delay;
    bit                       pending;
    int                       pops [NT];
    int                       timeouts;
    int                       chk_errors;

    tb_clock_gen #(.PERIOD(4.0), .RST_CYCLES(16)) tb_clock_gen_i (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    fetch_unit_top fetch_unit_top_i (
        .i_clk          (clk),
        .i_rstn         (rstn),
        .i_restart      (restart),
        .o_bus_req_re   (req_re),
        .o_bus_req_addr (req_addr),
        .i_bus_rsp_ack  (ack),
        .i_bus_rsp_data (rsp_data),
        .i_bus_rsp_err  (rsp_err),
        .i_ibuf_re      (ibuf_re),
        .o_ibuf_avail   (avail),
        .o_ibuf_instr   (instr),
        .o_ibuf_berr    (berr)
    );

    tb_fetch_checker tb_fetch_checker_i (
        .i_clk          (clk),
        .i_rstn         (rstn),
        .i_restart      (restart),
        .i_phase        (phase),
        .i_bus_req_re   (req_re),
        .i_bus_req_addr (req_addr),
        .i_bus_rsp_ack  (ack),
        .i_ibuf_re      (ibuf_re),
        .i_ibuf_avail   (avail),
        .i_ibuf_instr   (instr),
        .i_ibuf_berr    (berr),
        .o_errors       (chk_errors)
    );

    bind fetch_unit_top fetch_assertions fetch_assertions_i (.*);

    function automatic logic [32:0] mem_word(input logic [31:0] addr);
        for (int i = 0; i < GOLD_N; i++)
            if (!$isunknown(gold[3*i]) && gold[3*i] == addr)
                return {gold[3*i+2][0], gold[3*i+1]};
        return {1'b0, addr ^ 32'hA5A5_A5A5};    // unlisted words
    endfunction

    // ======================================================================
    // stimulus and bus memory, 1 ns after the edge
    // ======================================================================
    always @(posedge clk) begin
        #1;
        restart     = restart_cmd;
        restart_cmd = 1'b0;
        ack         = 1'b0;
        r           = $random(seed);
        ibuf_re     = {(phase == 2'd2) ? r[3] : 1'b0, r[2:0]};  // thread 3 idle in phase one
        if (!rstn || restart || !req_re) begin
            pending = 1'b0;                 // restart drops the request
        end else begin
            if (!pending) begin
                pending = 1'b1;
                delay   = (r >> 8) & 3;     // 0 to 3 idle cycles
            end
            if (delay == 0) begin
                {rsp_err, rsp_data} = mem_word(req_addr);
                ack     = 1'b1;
                pending = 1'b0;
            end else begin
                delay--;
            end
        end
    end

    always @(negedge clk)
        for (int t = 0; t < NT; t++)
            if (rstn && ibuf_re[t] && avail[t])
                pops[t]++;

    task automatic clear_pops();
        for (int t = 0; t < NT; t++)
            pops[t] = 0;
    endtask

    initial begin
        int cyc;
        $readmemh("verif/fetch_golden.txt", gold);
        seed        = 32'h552f_c8f8;
        restart     = 1'b0;
        restart_cmd = 1'b0;
        ack         = 1'b0;
        rsp_data    = '0;
        rsp_err     = 1'b0;
        ibuf_re     = '0;
        phase       = 2'd0;
        pending     = 1'b0;
        delay       = 0;
        timeouts    = 0;
        clear_pops();

        cyc = 0;
        while (!rstn && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!rstn) begin
            $display("reset was never released");
            timeouts++;
        end

        // phase one, thread 3 never drains
        phase = 2'd1;
        clear_pops();
        cyc = 0;
        while (pops[0] + pops[1] + pops[2] < 40 && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (cyc >= TIMEOUT) begin
            $display("phase one pops did not complete in time");
            timeouts++;
        end

        restart_cmd = 1'b1;
        @(negedge clk);
        @(negedge clk);
        phase = 2'd2;                       // all threads drain
        clear_pops();
        cyc = 0;
        while ((pops[0] < 8 || pops[1] < 8 || pops[2] < 8 || pops[3] < 8)
               && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (cyc >= TIMEOUT) begin
            $display("phase two pops did not complete in time");
            timeouts++;
        end
        repeat (4) @(negedge clk);

        $display("checker errors %0d, timeouts %0d", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule : tb_fetch_unit

`default_nettype wire

//--- verif/fetch_golden.txt
// columns: word address, instruction data, bus error flag
// one triple per line, unlisted addresses read as address xor a5a5a5a5
00001000 00000013 0
00001004 00100093 0
00001008 00208113 0
0000100c deadbeef 1
00001010 0000006f 0
00001014 00310193 0
00001400 00400213 0
00001404 00520293 0
00001408 0ff00313 1
0000140c 00b303b3 0
00001410 40728433 0
00001414 00000073 0
00001800 12345037 0
00001804 00a00513 0
00001808 00b50593 0
0000180c bad0c0de 1
00001810 00c58633 0
00001814 0000100f 0
00001c00 fff00693 0
00001c04 00d68733 1
00001c08 00e707b3 0
00001c0c 00f78833 0
00001c10 10500073 0
00001c14 30200073 1

//--- project.f
+incdir+logic
logic/fetch_pkg.sv
logic/fetch_sequencer.sv
logic/thread_pc_bank.sv
logic/prefetch_buffer.sv
logic/fetch_unit_top.sv
verif/tb_clock_gen.sv
verif/fetch_assertions.sv
verif/tb_fetch_checker.sv
verif/tb_fetch_unit.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/fetch_pkg.sv
      - logic/fetch_sequencer.sv
      - logic/thread_pc_bank.sv
      - logic/prefetch_buffer.sv
      - logic/fetch_unit_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_clock_gen.sv
      - verif/fetch_assertions.sv
      - verif/tb_fetch_checker.sv
      - verif/tb_fetch_unit.sv
